// ==== bench/gat_vectors.txt ====
// Per run 27 hex words: weight rows 0-3, feature rows 0-7 (element 3 in the top byte),
// probe node, expected outputs 0-7, readout sums 0-3, raw probe word, busy count.
// Run 0 weights
00000001
00000100
01010101
04040404
// Run 0 features
04030201
1E140AFB
64646464
80808080
00000007
00000000
01FE05FD
FF0AEC32
// Run 0 probe node
00000001
// Run 0 expected outputs
280A0201
7F370A00
7F7F6464
00000000
1C070007
00000000
04010500
7F270032
// Run 0 readout sums, raw probe, busy count
0000009E 00000075 000000EF 000001C5
FFFFFFFB
00000088
// Run 1 weights, with negative elements
FFFFFFFF 0000FF02 00030000 FE000000
// Run 1 features
281E140A D8E2ECF6 9C32013C 7F807F80
00000000 01010101 E2149CCE 09F9FD05
// Run 1 probe node
00000006
// Run 1 expected outputs
005A0000 50000064 7F7F7700 00000002
00000000 00030100 3C3C007F 00000D00
// Run 1 readout sums, raw probe, busy count
000000E5 00000085 00000118 0000010B
000000A0
00000088

// ==== bench/tb_gat_top.sv ====
`timescale 1ns/10ps
`include "gat_macros.svh"

module tb_gat_top;

  localparam int CLK_PERIOD  = 20;
  localparam int RUN_NUM     = 2;
  localparam int RUN_WORDS   = 27;
  localparam int RUN_CYCLES  = (`GAT_MAC_CYCLES + 1) * `GAT_NODE_NUM;
  localparam int LOAD_CYCLES = 40;  // Writes, start and settling around one run.
  localparam int WATCHDOG_NS = 2 * RUN_NUM * (RUN_CYCLES + LOAD_CYCLES) * CLK_PERIOD;

  // Word offsets inside one run of the vector file.
  localparam int OFS_WGT     = 0;
  localparam int OFS_FEAT    = 4;
  localparam int OFS_PROBE_N = 12;
  localparam int OFS_OUT     = 13;
  localparam int OFS_SUM     = 21;
  localparam int OFS_PROBE   = 25;
  localparam int OFS_COUNT   = 26;

  localparam debug_pkg::flags_t ALL_FLAGS = 32'h0000_003F; // Bits 0 to 5.

  logic                             clk;
  logic                             rst_n;
  logic                             wr_i;
  gat_pkg::wr_sel_e                 wr_sel_i;
  gat_pkg::node_t                   wr_addr_i;
  gat_pkg::vec_t                    wr_data_i;
  logic                             start_i;
  logic                             dbg_clr_i;
  gat_pkg::node_t                   probe_node_i;
  logic                             out_vld_o;
  gat_pkg::node_t                   out_node_o;
  gat_pkg::vec_t                    out_feat_o;
  logic                             done_o;
  gat_pkg::sum_t [`GAT_OUT_DIM-1:0] readout_o;
  debug_pkg::flags_t                flags_o;
  debug_pkg::count_t                count_o;
  debug_pkg::probe_t                probe_o;

  logic [31:0] vec_mem [RUN_WORDS*RUN_NUM];
  int          mismatch_cnt;
  int          fail_cnt;

  gat_top u_gat_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_i         (wr_i),
    .wr_sel_i     (wr_sel_i),
    .wr_addr_i    (wr_addr_i),
    .wr_data_i    (wr_data_i),
    .start_i      (start_i),
    .dbg_clr_i    (dbg_clr_i),
    .probe_node_i (probe_node_i),
    .out_vld_o    (out_vld_o),
    .out_node_o   (out_node_o),
    .out_feat_o   (out_feat_o),
    .done_o       (done_o),
    .readout_o    (readout_o),
    .flags_o      (flags_o),
    .count_o      (count_o),
    .probe_o      (probe_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt + 1);
    $display("Test failed");
    $finish;
  end

  // Inputs change 2 ns after the rising edge.
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic write_row(input gat_pkg::wr_sel_e sel, input gat_pkg::node_t addr,
                           input gat_pkg::vec_t data);
    wr_i      = 1'b1;
    wr_sel_i  = sel;
    wr_addr_i = addr;
    wr_data_i = data;
    tick();
    wr_i      = 1'b0;
  endtask

  task automatic check_vec(input string what, input gat_pkg::vec_t got,
                           input gat_pkg::vec_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_node(input string what, input gat_pkg::node_t got,
                            input gat_pkg::node_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_sum(input string what, input gat_pkg::sum_t got,
                           input gat_pkg::sum_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input string what, input debug_pkg::flags_t got,
                             input debug_pkg::flags_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s flags are %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input debug_pkg::count_t got,
                             input debug_pkg::count_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s busy count is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_probe(input string what, input debug_pkg::probe_t got,
                             input debug_pkg::probe_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s probe is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_debug_clear(input string what);
    check_flags(what, flags_o, '0);
    check_count(what, count_o, '0);
    check_probe(what, probe_o, '0);
  endtask

  // Load one run, start it and follow every output until done.
  task automatic run_graph(input int run);
    int    base;
    int    node_exp;
    string tag;
    base     = run * RUN_WORDS;
    node_exp = 0;
    tag      = $sformatf("run %0d", run);
    probe_node_i = gat_pkg::node_t'(vec_mem[base + OFS_PROBE_N]);
    for (int r = 0; r < `GAT_OUT_DIM; r++) begin
      write_row(gat_pkg::WR_WGT, gat_pkg::node_t'(r), vec_mem[base + OFS_WGT + r]);
    end
    for (int n = 0; n < `GAT_NODE_NUM; n++) begin
      write_row(gat_pkg::WR_FEAT, gat_pkg::node_t'(n), vec_mem[base + OFS_FEAT + n]);
    end
    start_i = 1'b1;
    tick();
    start_i = 1'b0;
    while (done_o !== 1'b1) begin
      if (out_vld_o === 1'b1) begin
        if (node_exp >= `GAT_NODE_NUM) begin
          fail_cnt++;
          $display("%s: more than %0d node results came out", tag, `GAT_NODE_NUM);
        end else begin
          check_node({tag, " out_node_o"}, out_node_o, gat_pkg::node_t'(node_exp));
          check_vec($sformatf("%s node %0d out_feat_o", tag, node_exp), out_feat_o,
                    vec_mem[base + OFS_OUT + node_exp]);
        end
        node_exp++;
      end
      tick();
    end
    if (node_exp != `GAT_NODE_NUM) begin
      fail_cnt++;
      $display("%s: done arrived after %0d node results instead of %0d", tag, node_exp,
               `GAT_NODE_NUM);
    end
    for (int i = 0; i < `GAT_OUT_DIM; i++) begin
      check_sum($sformatf("%s readout %0d", tag, i), readout_o[i],
                gat_pkg::sum_t'(vec_mem[base + OFS_SUM + i][15:0]));
    end
    tick();  // Debug outputs lag the done pulse by one cycle.
    check_flags(tag, flags_o, ALL_FLAGS);
    check_count(tag, count_o, vec_mem[base + OFS_COUNT]);
    check_probe(tag, probe_o, vec_mem[base + OFS_PROBE]);
  endtask

  initial begin
    mismatch_cnt = 0;
    fail_cnt     = 0;
    rst_n        = 1'b0;
    wr_i         = 1'b0;
    wr_sel_i     = gat_pkg::WR_FEAT;
    wr_addr_i    = '0;
    wr_data_i    = '0;
    start_i      = 1'b0;
    dbg_clr_i    = 1'b0;
    probe_node_i = '0;
    $readmemh("bench/gat_vectors.txt", vec_mem);
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Idle after reset, nothing may come out.
    repeat (4) begin
      if (out_vld_o !== 1'b0) begin
        fail_cnt++;
        $display("out_vld_o is not low at %0t before any data was loaded", $time);
      end
      tick();
    end
    check_debug_clear("after reset");
    run_graph(0);
    dbg_clr_i = 1'b1;
    tick();
    dbg_clr_i = 1'b0;
    check_debug_clear("after debug clear");
    run_graph(1);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== common/debug_pkg.sv ====
package debug_pkg;

  typedef logic [31:0] flags_t; // Sticky stage flags, upper bits zero.
  typedef logic [31:0] count_t; // Busy cycle count.
  typedef logic [31:0] probe_t; // Captured raw accumulator, sign-extended.

  // Bit positions in flags_t.
  localparam int unsigned FLG_WGT_WR  = 0;
  localparam int unsigned FLG_FEAT_WR = 1;
  localparam int unsigned FLG_START   = 2;
  localparam int unsigned FLG_RES     = 3;
  localparam int unsigned FLG_OUT     = 4;
  localparam int unsigned FLG_DONE    = 5;

endpackage

// ==== common/gat_macros.svh ====
`ifndef GAT_MACROS_SVH
`define GAT_MACROS_SVH

// Graph size.
`define GAT_NODE_NUM 8

// Feature vector lengths.
`define GAT_FEAT_DIM 4
`define GAT_OUT_DIM  4

// Element and accumulator widths.
`define GAT_DATA_W 8
`define GAT_ACC_W  20

// One multiply-accumulate per weight element.
`define GAT_MAC_CYCLES (`GAT_FEAT_DIM * `GAT_OUT_DIM)

`endif

// ==== common/gat_pkg.sv ====
`include "gat_macros.svh"

package gat_pkg;

  // One signed feature or weight element.
  typedef logic signed [`GAT_DATA_W-1:0] data_t;

  // Feature row, weight row or clamped output row.
  typedef data_t [`GAT_FEAT_DIM-1:0] vec_t;

  typedef logic signed [`GAT_ACC_W-1:0] acc_t;
  typedef acc_t [`GAT_OUT_DIM-1:0] acc_vec_t;

  typedef logic [$clog2(`GAT_NODE_NUM)-1:0] node_t;
  typedef logic [$clog2(`GAT_OUT_DIM)-1:0]  row_t;

  typedef logic signed [15:0] sum_t; // Readout sum over all nodes.

  typedef enum logic {
    WR_FEAT = 1'b0,
    WR_WGT  = 1'b1
  } wr_sel_e;

endpackage

// ==== hw/aggregator.sv ====
`timescale 1ns/10ps
`include "gat_macros.svh"

module aggregator (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            res_vld_i,
  input  gat_pkg::node_t                  res_node_i,
  input  gat_pkg::acc_vec_t               res_acc_i,
  output logic                            out_vld_o,
  output gat_pkg::node_t                  out_node_o,
  output gat_pkg::vec_t                   out_feat_o,
  output logic                            done_o,
  output gat_pkg::sum_t [`GAT_OUT_DIM-1:0] readout_o
);

  localparam gat_pkg::data_t SAT_MAX   = gat_pkg::data_t'(2**(`GAT_DATA_W-1) - 1);
  localparam gat_pkg::node_t LAST_NODE = gat_pkg::node_t'(`GAT_NODE_NUM - 1);

  gat_pkg::vec_t                    clamp;
  gat_pkg::sum_t [`GAT_OUT_DIM-1:0] sum_q;
  logic                             last_out;

  // ReLU, then saturate to the positive byte range.
  always_comb begin
    for (int i = 0; i < `GAT_OUT_DIM; i++) begin
      if (res_acc_i[i] < 0) begin
        clamp[i] = '0;
      end else if (res_acc_i[i] > SAT_MAX) begin
        clamp[i] = SAT_MAX;
      end else begin
        clamp[i] = res_acc_i[i][`GAT_DATA_W-1:0];
      end
    end
  end

  assign last_out = out_vld_o && (out_node_o == LAST_NODE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_vld_o  <= 1'b0;
      out_node_o <= '0;
      out_feat_o <= '0;
      done_o     <= 1'b0;
      readout_o  <= '0;
      sum_q      <= '0;
    end else begin
      out_vld_o <= res_vld_i;
      done_o    <= last_out;
      if (res_vld_i) begin
        out_node_o <= res_node_i;
        out_feat_o <= clamp;
        for (int i = 0; i < `GAT_OUT_DIM; i++) begin
          sum_q[i] <= sum_q[i] + gat_pkg::sum_t'(clamp[i]);
        end
      end
      // Sums are complete while the last node is on the output.
      if (last_out) begin
        readout_o <= sum_q;
        sum_q     <= '0;   // Ready for the next run.
      end
    end
  end

endmodule

// ==== hw/debugger.sv ====
`timescale 1ns/10ps

module debugger (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dbg_clr_i,
  input  logic              wr_i,
  input  gat_pkg::wr_sel_e  wr_sel_i,
  input  logic              start_i,
  input  logic              busy_i,
  input  logic              res_vld_i,
  input  gat_pkg::node_t    res_node_i,
  input  gat_pkg::acc_t     res_acc0_i,
  input  logic              out_vld_i,
  input  logic              done_i,
  input  gat_pkg::node_t    probe_node_i,
  output debug_pkg::flags_t flags_o,
  output debug_pkg::count_t count_o,
  output debug_pkg::probe_t probe_o
);

  localparam int ACC_W = $bits(gat_pkg::acc_t);
  localparam int PAD_W = $bits(debug_pkg::probe_t) - ACC_W;

  debug_pkg::flags_t evt;
  debug_pkg::flags_t flags_d;
  debug_pkg::count_t count_d;
  debug_pkg::probe_t probe_d;
  logic              probe_hit;

  // One bit per stage event, unused bits stay zero.
  always_comb begin
    evt = '0;
    evt[debug_pkg::FLG_WGT_WR]  = wr_i && (wr_sel_i == gat_pkg::WR_WGT);
    evt[debug_pkg::FLG_FEAT_WR] = wr_i && (wr_sel_i == gat_pkg::WR_FEAT);
    evt[debug_pkg::FLG_START]   = start_i;
    evt[debug_pkg::FLG_RES]     = res_vld_i;
    evt[debug_pkg::FLG_OUT]     = out_vld_i;
    evt[debug_pkg::FLG_DONE]    = done_i;
  end

  assign flags_d   = flags_o | evt;  // Sticky.
  assign count_d   = busy_i ? count_o + 1'b1 : count_o;
  assign probe_hit = res_vld_i && (res_node_i == probe_node_i);

  // Keep the raw signed value, no clamping here.
  assign probe_d = probe_hit ? {{PAD_W{res_acc0_i[ACC_W-1]}}, res_acc0_i} : probe_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_o <= '0;
      count_o <= '0;
      probe_o <= '0;
    end else if (dbg_clr_i) begin
      flags_o <= '0;
      count_o <= '0;
      probe_o <= '0;
    end else begin
      flags_o <= flags_d;
      count_o <= count_d;
      probe_o <= probe_d;
    end
  end

endmodule

// ==== hw/dmvm/dmvm_engine.sv ====
`timescale 1ns/10ps
`include "gat_macros.svh"

module dmvm_engine (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  gat_pkg::vec_t     feat_i,
  input  gat_pkg::vec_t     wgt_i,
  output gat_pkg::node_t    rd_node_o,
  output gat_pkg::row_t     rd_row_o,
  output logic              busy_o,
  output logic              res_vld_o,
  output gat_pkg::node_t    res_node_o,
  output gat_pkg::acc_vec_t res_acc_o
);

  localparam int STEP_W = $clog2(`GAT_MAC_CYCLES + 1);
  localparam int COL_W  = $clog2(`GAT_FEAT_DIM);
  localparam int ROW_W  = $bits(gat_pkg::row_t);

  localparam logic [STEP_W-1:0] WB_STEP   = STEP_W'(`GAT_MAC_CYCLES);
  localparam logic [STEP_W-1:0] LAST_MAC  = STEP_W'(`GAT_MAC_CYCLES - 1);
  localparam gat_pkg::node_t    LAST_NODE = gat_pkg::node_t'(`GAT_NODE_NUM - 1);

  logic [STEP_W-1:0] step_q;    // Row and column inside the node, then writeback.
  gat_pkg::node_t    node_q;
  gat_pkg::acc_vec_t acc_q;
  logic              busy_q;
  logic              res_vld_q;

  logic [COL_W-1:0]  col;
  gat_pkg::row_t     row;
  logic              mac_en;
  logic              wb_en;
  logic signed [2*`GAT_DATA_W-1:0] mac_prod;

  assign col    = step_q[COL_W-1:0];
  assign row    = step_q[COL_W +: ROW_W];
  assign mac_en = busy_q && (step_q < WB_STEP);
  assign wb_en  = busy_q && (step_q == WB_STEP);

  // Feature element times weight element of the current row.
  assign mac_prod = $signed(feat_i[col]) * $signed(wgt_i[col]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      step_q    <= '0;
      node_q    <= '0;
      acc_q     <= '0;
      res_vld_q <= 1'b0;
    end else begin
      // Last MAC lands on this edge, so the result is whole next cycle.
      res_vld_q <= mac_en && (step_q == LAST_MAC);
      if (!busy_q) begin
        if (start_i) begin
          busy_q <= 1'b1;
          step_q <= '0;
          node_q <= '0;
          acc_q  <= '0;
        end
      end else if (wb_en) begin
        step_q <= '0;
        acc_q  <= '0;                 // Fresh accumulators for the next node.
        node_q <= node_q + 1'b1;
        if (node_q == LAST_NODE) begin
          busy_q <= 1'b0;
        end
      end else if (mac_en) begin
        acc_q[row] <= acc_q[row] + gat_pkg::acc_t'(mac_prod);
        step_q     <= step_q + 1'b1;
      end
    end
  end

  assign rd_node_o  = node_q;
  assign rd_row_o   = row;
  assign busy_o     = busy_q;
  assign res_vld_o  = res_vld_q;
  assign res_node_o = node_q;
  assign res_acc_o  = acc_q;  // Only meaningful while res_vld_o is high.

endmodule

// ==== hw/feat_loader.sv ====
`timescale 1ns/10ps
`include "gat_macros.svh"

module feat_loader (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_i,
  input  gat_pkg::wr_sel_e wr_sel_i,
  input  gat_pkg::node_t   wr_addr_i,
  input  gat_pkg::vec_t    wr_data_i,
  input  gat_pkg::node_t   rd_node_i,
  input  gat_pkg::row_t    rd_row_i,
  output gat_pkg::vec_t    feat_o,
  output gat_pkg::vec_t    wgt_o
);

  localparam int ROW_W = $bits(gat_pkg::row_t);

  gat_pkg::vec_t feat_mem [`GAT_NODE_NUM];
  gat_pkg::vec_t wgt_mem  [`GAT_OUT_DIM];

  gat_pkg::row_t wr_row;
  logic          feat_we;
  logic          wgt_we;

  // Weight rows only need the low address bits.
  assign wr_row  = wr_addr_i[ROW_W-1:0];
  assign feat_we = wr_i && (wr_sel_i == gat_pkg::WR_FEAT);
  assign wgt_we  = wr_i && (wr_sel_i == gat_pkg::WR_WGT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_mem <= '{default: '0};
    end else if (feat_we) begin
      feat_mem[wr_addr_i] <= wr_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wgt_mem <= '{default: '0};
    end else if (wgt_we) begin
      wgt_mem[wr_row] <= wr_data_i;
    end
  end

  // Combinational reads, the engine samples them in the same cycle.
  assign feat_o = feat_mem[rd_node_i];
  assign wgt_o  = wgt_mem[rd_row_i];

endmodule

// ==== hw/gat_top.sv ====
`timescale 1ns/10ps
`include "gat_macros.svh"

module gat_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             wr_i,
  input  gat_pkg::wr_sel_e                 wr_sel_i,
  input  gat_pkg::node_t                   wr_addr_i,
  input  gat_pkg::vec_t                    wr_data_i,
  input  logic                             start_i,
  input  logic                             dbg_clr_i,
  input  gat_pkg::node_t                   probe_node_i,
  output logic                             out_vld_o,
  output gat_pkg::node_t                   out_node_o,
  output gat_pkg::vec_t                    out_feat_o,
  output logic                             done_o,
  output gat_pkg::sum_t [`GAT_OUT_DIM-1:0] readout_o,
  output debug_pkg::flags_t                flags_o,
  output debug_pkg::count_t                count_o,
  output debug_pkg::probe_t                probe_o
);

  gat_pkg::node_t    rd_node;
  gat_pkg::row_t     rd_row;
  gat_pkg::vec_t     feat;
  gat_pkg::vec_t     wgt;
  logic              busy;
  logic              res_vld;
  gat_pkg::node_t    res_node;
  gat_pkg::acc_vec_t res_acc;

  feat_loader u_feat_loader (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_i      (wr_i),
    .wr_sel_i  (wr_sel_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .rd_node_i (rd_node),
    .rd_row_i  (rd_row),
    .feat_o    (feat),
    .wgt_o     (wgt)
  );

  dmvm_engine u_dmvm_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_i),
    .feat_i     (feat),
    .wgt_i      (wgt),
    .rd_node_o  (rd_node),
    .rd_row_o   (rd_row),
    .busy_o     (busy),
    .res_vld_o  (res_vld),
    .res_node_o (res_node),
    .res_acc_o  (res_acc)
  );

  aggregator u_aggregator (
    .clk        (clk),
    .rst_n      (rst_n),
    .res_vld_i  (res_vld),
    .res_node_i (res_node),
    .res_acc_i  (res_acc),
    .out_vld_o  (out_vld_o),
    .out_node_o (out_node_o),
    .out_feat_o (out_feat_o),
    .done_o     (done_o),
    .readout_o  (readout_o)
  );

  // Probe sees only the first output element of each node.
  debugger u_debugger (
    .clk          (clk),
    .rst_n        (rst_n),
    .dbg_clr_i    (dbg_clr_i),
    .wr_i         (wr_i),
    .wr_sel_i     (wr_sel_i),
    .start_i      (start_i),
    .busy_i       (busy),
    .res_vld_i    (res_vld),
    .res_node_i   (res_node),
    .res_acc0_i   (res_acc[0]),
    .out_vld_i    (out_vld_o),
    .done_i       (done_o),
    .probe_node_i (probe_node_i),
    .flags_o      (flags_o),
    .count_o      (count_o),
    .probe_o      (probe_o)
  );

endmodule

// ==== project.f ====
+incdir+common
common/gat_pkg.sv
common/debug_pkg.sv
hw/feat_loader.sv
hw/dmvm/dmvm_engine.sv
hw/aggregator.sv
hw/debugger.sv
hw/gat_top.sv
bench/tb_gat_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the GAT testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_gat_top -o tb_gat_top

sim_out=$(./obj_dir/tb_gat_top)
echo "$sim_out"

if echo "$sim_out" | grep -q '^Test passed$'; then
  exit 0
fi
exit 1
